// ==== hdl/trigger_pkg.sv ====
package trigger_pkg;

    localparam int BUS_DATA_W = 8;
    localparam int COUNTER_W  = 32;

    // byte addresses on the register bus
    localparam int ADDR_SOFT_RST_VERSION    = 0;  // write resets, read gives version
    localparam int ADDR_CONF                = 1;
    localparam int ADDR_TRIGGER_COUNTER     = 8;  // 8..11, lsb first
    localparam int ADDR_LOST_DATA_CNT       = 12;
    localparam int ADDR_TRIGGER_SELECT      = 13;
    localparam int ADDR_VETO_SELECT         = 17;
    localparam int ADDR_TRIGGER_INVERT      = 21;
    localparam int ADDR_TRIGGER_COUNTER_MAX = 25; // 25..28, lsb first
    localparam int ADDR_TRIGGER_THRESHOLD   = 33;
    localparam int ADDR_SOFT_TRIGGER        = 34;
    localparam int ADDR_LAST_CONF           = 33;

    localparam int CONF_ENABLE_BIT = 3; // in the conf register

    localparam logic [BUS_DATA_W-1:0] CONTROLLER_VERSION = 8'd10;

    // reset values
    localparam logic [BUS_DATA_W-1:0] REG_RESET         = '0;
    localparam logic [COUNTER_W-1:0]  COUNTER_MAX_RESET = '0; // zero means no limit

    localparam logic [BUS_DATA_W-1:0] LOST_CNT_MAX = 8'hFF; // saturation point

    // msb of every trigger word is set, count below it
    localparam logic [COUNTER_W-1:0] TRIGGER_WORD_MARK = 32'h8000_0000;

endpackage

// ==== hdl/trigger_regs.sv ====
`timescale 1ns/1ps

module trigger_regs #(
    parameter int ABUSWIDTH = 16
) (
    input  logic                                bus_clk,
    input  logic                                rst,
    input  logic [ABUSWIDTH-1:0]                bus_add,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  bus_data_in,
    input  logic                                bus_wr,
    input  logic                                bus_rd,
    input  logic [trigger_pkg::COUNTER_W-1:0]   trigger_count,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  lost_count,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  bus_data_out,
    output logic                                block_rst,
    output logic                                conf_enable,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_threshold,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_select,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_invert,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  veto_select,
    output logic [trigger_pkg::COUNTER_W-1:0]   counter_max,
    output logic                                counter_set,
    output logic [trigger_pkg::COUNTER_W-1:0]   counter_set_value,
    output logic                                soft_trigger
);
    import trigger_pkg::*;

    logic [31:0]           addr;
    logic                  soft_rst_q;
    logic [BUS_DATA_W-1:0] conf;
    logic [23:0]           preset_lo;  // bytes 8..10, wait for the write of 11
    logic [COUNTER_W-9:0]  cnt_buf;    // upper bytes, frozen on a read of 8

    assign addr = 32'(bus_add);

    // one cycle of internal reset after a write to address 0
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            soft_rst_q <= 1'b0;
        else
            soft_rst_q <= bus_wr && addr == ADDR_SOFT_RST_VERSION;
    end

    assign block_rst = rst | soft_rst_q;

    always_ff @(posedge bus_clk)
    begin
        if (block_rst)
            soft_trigger <= 1'b0;
        else
            soft_trigger <= bus_wr && addr == ADDR_SOFT_TRIGGER;
    end

    assign counter_set       = bus_wr && addr == ADDR_TRIGGER_COUNTER + 3;
    assign counter_set_value = {bus_data_in, preset_lo};
    assign conf_enable       = conf[CONF_ENABLE_BIT];

    always_ff @(posedge bus_clk)
    begin
        if (block_rst)
        begin
            conf              <= REG_RESET;
            preset_lo         <= '0;
            trigger_select    <= REG_RESET;
            veto_select       <= REG_RESET;
            trigger_invert    <= REG_RESET;
            counter_max       <= COUNTER_MAX_RESET;
            trigger_threshold <= REG_RESET;
        end
        else if (bus_wr && addr <= ADDR_LAST_CONF)
        begin
            case (addr)
                ADDR_CONF:                    conf <= bus_data_in;
                ADDR_TRIGGER_COUNTER:         preset_lo[7:0] <= bus_data_in;
                ADDR_TRIGGER_COUNTER + 1:     preset_lo[15:8] <= bus_data_in;
                ADDR_TRIGGER_COUNTER + 2:     preset_lo[23:16] <= bus_data_in;
                ADDR_TRIGGER_SELECT:          trigger_select <= bus_data_in;
                ADDR_VETO_SELECT:             veto_select <= bus_data_in;
                ADDR_TRIGGER_INVERT:          trigger_invert <= bus_data_in;
                ADDR_TRIGGER_COUNTER_MAX:     counter_max[7:0] <= bus_data_in;
                ADDR_TRIGGER_COUNTER_MAX + 1: counter_max[15:8] <= bus_data_in;
                ADDR_TRIGGER_COUNTER_MAX + 2: counter_max[23:16] <= bus_data_in;
                ADDR_TRIGGER_COUNTER_MAX + 3: counter_max[31:24] <= bus_data_in;
                ADDR_TRIGGER_THRESHOLD:       trigger_threshold <= bus_data_in;
                default: ;
            endcase
        end
    end

    always_ff @(posedge bus_clk)
    begin
        if (block_rst)
            cnt_buf <= '0;
        else if (bus_rd && addr == ADDR_TRIGGER_COUNTER)
            cnt_buf <= trigger_count[COUNTER_W-1:8];
    end

    // read data, one cycle after the strobe
    always_ff @(posedge bus_clk)
    begin
        if (bus_rd)
        begin
            case (addr)
                ADDR_SOFT_RST_VERSION:        bus_data_out <= CONTROLLER_VERSION;
                ADDR_CONF:                    bus_data_out <= conf;
                ADDR_TRIGGER_COUNTER:         bus_data_out <= trigger_count[7:0];
                ADDR_TRIGGER_COUNTER + 1:     bus_data_out <= cnt_buf[7:0];
                ADDR_TRIGGER_COUNTER + 2:     bus_data_out <= cnt_buf[15:8];
                ADDR_TRIGGER_COUNTER + 3:     bus_data_out <= cnt_buf[23:16];
                ADDR_LOST_DATA_CNT:           bus_data_out <= lost_count;
                ADDR_TRIGGER_SELECT:          bus_data_out <= trigger_select;
                ADDR_VETO_SELECT:             bus_data_out <= veto_select;
                ADDR_TRIGGER_INVERT:          bus_data_out <= trigger_invert;
                ADDR_TRIGGER_COUNTER_MAX:     bus_data_out <= counter_max[7:0];
                ADDR_TRIGGER_COUNTER_MAX + 1: bus_data_out <= counter_max[15:8];
                ADDR_TRIGGER_COUNTER_MAX + 2: bus_data_out <= counter_max[23:16];
                ADDR_TRIGGER_COUNTER_MAX + 3: bus_data_out <= counter_max[31:24];
                ADDR_TRIGGER_THRESHOLD:       bus_data_out <= trigger_threshold;
                default:                      bus_data_out <= '0; // unmapped
            endcase
        end
    end

endmodule

// ==== hdl/trigger_input_select.sv ====
`timescale 1ns/1ps

module trigger_input_select #(
    parameter int WIDTH = 8
) (
    input  logic                                bus_clk,
    input  logic [WIDTH-1:0]                    trigger,
    input  logic [WIDTH-1:0]                    trigger_veto,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_select,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_invert,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  veto_select,
    output logic                                trigger_line,
    output logic                                veto_line
);

    logic [WIDTH-1:0] trig_meta;
    logic [WIDTH-1:0] trig_sync;
    logic [WIDTH-1:0] veto_meta;
    logic [WIDTH-1:0] veto_sync;

    // pins are asynchronous, two flops each
    always_ff @(posedge bus_clk)
    begin
        trig_meta <= trigger;
        trig_sync <= trig_meta;
        veto_meta <= trigger_veto;
        veto_sync <= veto_meta;
    end

    // invert first, then mask and merge
    assign trigger_line = |((trig_sync ^ trigger_invert[WIDTH-1:0]) & trigger_select[WIDTH-1:0]);
    assign veto_line    = |(veto_sync & veto_select[WIDTH-1:0]);

endmodule

// ==== hdl/trigger_fsm.sv ====
`timescale 1ns/1ps

module trigger_fsm (
    input  logic                                bus_clk,
    input  logic                                rst,
    input  logic                                trigger_line,
    input  logic                                soft_trigger,
    input  logic                                veto_line,
    input  logic                                conf_enable,
    input  logic                                limit_reached,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  trigger_threshold,
    input  logic                                ext_ack_enable,
    input  logic                                trigger_ack,
    input  logic [trigger_pkg::COUNTER_W-1:0]   trigger_count,
    output logic                                trigger_accepted,
    output logic                                trigger_enabled,
    output logic                                word_write,
    output logic [trigger_pkg::COUNTER_W-1:0]   trigger_word
);
    import trigger_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_COUNT, ST_WAIT_ACK, ST_WAIT_LOW} state_t;

    state_t                state;
    logic [BUS_DATA_W-1:0] hi_cnt;     // consecutive qualified cycles
    logic [BUS_DATA_W-1:0] hi_target;
    logic                  trig_eff;
    logic                  qualified;
    logic                  ack;

    assign trig_eff  = trigger_line | soft_trigger;
    assign qualified = trig_eff && !veto_line && trigger_enabled;
    assign hi_target = (trigger_threshold == '0) ? 8'd1 : trigger_threshold;
    assign ack       = ext_ack_enable ? trigger_ack : trigger_accepted; // internal ack is the accept
    assign word_write = trigger_accepted;

    always_ff @(posedge bus_clk)
    begin
        if (rst)
            trigger_enabled <= 1'b0;
        else
            trigger_enabled <= conf_enable && !limit_reached;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            state            <= ST_IDLE;
            hi_cnt           <= '0;
            trigger_accepted <= 1'b0;
        end
        else
        begin
            trigger_accepted <= 1'b0;
            case (state)
                ST_IDLE, ST_COUNT:
                begin
                    if (!qualified)
                    begin
                        state  <= ST_IDLE;
                        hi_cnt <= '0;
                    end
                    else if (hi_cnt + 8'd1 >= hi_target)
                    begin
                        state            <= ST_WAIT_ACK;
                        hi_cnt           <= '0;
                        trigger_accepted <= 1'b1;
                    end
                    else
                    begin
                        state  <= ST_COUNT;
                        hi_cnt <= hi_cnt + 8'd1;
                    end
                end
                ST_WAIT_ACK:
                    if (ack)
                        state <= ST_WAIT_LOW;
                ST_WAIT_LOW:
                    if (!trig_eff)
                        state <= ST_IDLE; // released, may accept again
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // count before the increment, captured with the accept
    always_ff @(posedge bus_clk)
    begin
        if (state != ST_WAIT_ACK && state != ST_WAIT_LOW)
            trigger_word <= TRIGGER_WORD_MARK | {1'b0, trigger_count[COUNTER_W-2:0]};
    end

endmodule

// ==== hdl/trigger_counter.sv ====
`timescale 1ns/1ps

module trigger_counter (
    input  logic                               bus_clk,
    input  logic                               rst,
    input  logic                               trigger_accepted,
    input  logic                               counter_set,
    input  logic [trigger_pkg::COUNTER_W-1:0]  counter_set_value,
    input  logic [trigger_pkg::COUNTER_W-1:0]  counter_max,
    output logic [trigger_pkg::COUNTER_W-1:0]  trigger_count,
    output logic                               limit_reached
);
    import trigger_pkg::*;

    // bus preset wins over an accept on the same edge
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            trigger_count <= '0;
        else if (counter_set)
            trigger_count <= counter_set_value;
        else if (trigger_accepted)
            trigger_count <= trigger_count + COUNTER_W'(1);
    end

    // a max of zero disables the limit
    assign limit_reached = (counter_max != COUNTER_MAX_RESET) && (trigger_count >= counter_max);

endmodule

// ==== hdl/event_fifo.sv ====
`timescale 1ns/1ps

module event_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                bus_clk,
    input  logic                                rst,
    input  logic                                word_write,
    input  logic [trigger_pkg::COUNTER_W-1:0]   trigger_word,
    input  logic                                fifo_read,
    output logic                                fifo_empty,
    output logic [trigger_pkg::COUNTER_W-1:0]   fifo_data,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  lost_count
);
    import trigger_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] OCC_FULL = (AW + 1)'(FIFO_DEPTH);

    logic [COUNTER_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          occ;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full       = occ == OCC_FULL;
    assign fifo_empty = occ == '0;
    assign push       = word_write && !full;
    assign pop        = fifo_read && !fifo_empty;
    assign fifo_data  = mem[rd_ptr]; // head word, no read latency

    always_ff @(posedge bus_clk)
    begin
        if (push)
            mem[wr_ptr] <= trigger_word;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ        <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + AW'(1);
            if (pop)
                rd_ptr <= rd_ptr + AW'(1);
            if (push && !pop)
                occ <= occ + (AW + 1)'(1);
            else if (pop && !push)
                occ <= occ - (AW + 1)'(1);
            // dropped word, count saturates
            if (word_write && full && lost_count != LOST_CNT_MAX)
                lost_count <= lost_count + 8'd1;
        end
    end

endmodule

// ==== hdl/trigger_controller_top.sv ====
`timescale 1ns/1ps

module trigger_controller_top #(
    parameter int ABUSWIDTH  = 16,
    parameter int WIDTH      = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                BUS_CLK,
    input  logic                                RST,
    input  logic [ABUSWIDTH-1:0]                BUS_ADD,
    input  logic [trigger_pkg::BUS_DATA_W-1:0]  BUS_DATA_IN,
    input  logic                                BUS_WR,
    input  logic                                BUS_RD,
    output logic [trigger_pkg::BUS_DATA_W-1:0]  BUS_DATA_OUT,
    input  logic [WIDTH-1:0]                    TRIGGER,
    input  logic [WIDTH-1:0]                    TRIGGER_VETO,
    input  logic                                EXT_TRIGGER_ENABLE,
    input  logic                                TRIGGER_ACKNOWLEDGE,
    output logic                                TRIGGER_ACCEPTED_FLAG,
    output logic                                TRIGGER_ENABLED,
    output logic [WIDTH-1:0]                    TRIGGER_SELECTED,
    input  logic                                FIFO_READ,
    output logic                                FIFO_EMPTY,
    output logic [trigger_pkg::COUNTER_W-1:0]   FIFO_DATA
);
    import trigger_pkg::*;

    logic                  block_rst;
    logic                  conf_enable;
    logic [BUS_DATA_W-1:0] trigger_threshold;
    logic [BUS_DATA_W-1:0] trigger_select;
    logic [BUS_DATA_W-1:0] trigger_invert;
    logic [BUS_DATA_W-1:0] veto_select;
    logic [COUNTER_W-1:0]  counter_max;
    logic                  counter_set;
    logic [COUNTER_W-1:0]  counter_set_value;
    logic                  soft_trigger;
    logic                  trigger_line;
    logic                  veto_line;
    logic [COUNTER_W-1:0]  trigger_count;
    logic                  limit_reached;
    logic                  word_write;
    logic [COUNTER_W-1:0]  trigger_word;
    logic [BUS_DATA_W-1:0] lost_count;

    assign TRIGGER_SELECTED = trigger_select[WIDTH-1:0];

    trigger_regs #(.ABUSWIDTH(ABUSWIDTH)) u_regs (
        .bus_clk(BUS_CLK), .rst(RST), .bus_add(BUS_ADD), .bus_data_in(BUS_DATA_IN),
        .bus_wr(BUS_WR), .bus_rd(BUS_RD), .trigger_count(trigger_count),
        .lost_count(lost_count), .bus_data_out(BUS_DATA_OUT), .block_rst(block_rst),
        .conf_enable(conf_enable), .trigger_threshold(trigger_threshold),
        .trigger_select(trigger_select), .trigger_invert(trigger_invert),
        .veto_select(veto_select), .counter_max(counter_max), .counter_set(counter_set),
        .counter_set_value(counter_set_value), .soft_trigger(soft_trigger)
    );

    trigger_input_select #(.WIDTH(WIDTH)) u_input_select (
        .bus_clk(BUS_CLK), .trigger(TRIGGER), .trigger_veto(TRIGGER_VETO),
        .trigger_select(trigger_select), .trigger_invert(trigger_invert),
        .veto_select(veto_select), .trigger_line(trigger_line), .veto_line(veto_line)
    );

    trigger_fsm u_fsm (
        .bus_clk(BUS_CLK), .rst(block_rst), .trigger_line(trigger_line),
        .soft_trigger(soft_trigger), .veto_line(veto_line), .conf_enable(conf_enable),
        .limit_reached(limit_reached), .trigger_threshold(trigger_threshold),
        .ext_ack_enable(EXT_TRIGGER_ENABLE), .trigger_ack(TRIGGER_ACKNOWLEDGE),
        .trigger_count(trigger_count), .trigger_accepted(TRIGGER_ACCEPTED_FLAG),
        .trigger_enabled(TRIGGER_ENABLED), .word_write(word_write),
        .trigger_word(trigger_word)
    );

    trigger_counter u_counter (
        .bus_clk(BUS_CLK), .rst(block_rst), .trigger_accepted(TRIGGER_ACCEPTED_FLAG),
        .counter_set(counter_set), .counter_set_value(counter_set_value),
        .counter_max(counter_max), .trigger_count(trigger_count),
        .limit_reached(limit_reached)
    );

    event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .bus_clk(BUS_CLK), .rst(block_rst), .word_write(word_write),
        .trigger_word(trigger_word), .fifo_read(FIFO_READ), .fifo_empty(FIFO_EMPTY),
        .fifo_data(FIFO_DATA), .lost_count(lost_count)
    );

endmodule

// ==== bench/trigger_fsm_checker.sv ====
`timescale 1ns/1ps

module trigger_fsm_checker (
    input logic        bus_clk,
    input logic        rst,
    input logic        trigger_accepted,
    input logic        trigger_enabled,
    input logic        word_write,
    input logic [31:0] trigger_word,
    input logic [31:0] trigger_count
);

    accept_single_cycle: assert property (@(posedge bus_clk) disable iff (rst)
        trigger_accepted |=> !trigger_accepted)
        else $error("trigger_accepted held for more than one cycle");

    // accept decided on the cycle before, enable must have been up then
    accept_only_enabled: assert property (@(posedge bus_clk) disable iff (rst)
        trigger_accepted |-> $past(trigger_enabled))
        else $error("trigger accepted while the trigger was not enabled");

    // marker set, count still the one from before its increment
    word_holds_count: assert property (@(posedge bus_clk) disable iff (rst)
        word_write |-> trigger_word == {1'b1, trigger_count[30:0]})
        else $error("trigger word does not hold the count before the increment");

endmodule

// ==== bench/tb_trigger_controller.sv ====
`timescale 1ns/1ps

module tb_trigger_controller;

    localparam int TIMEOUT_CYCLES = 200;

    logic        bus_clk;
    logic        rst;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;
    logic [7:0]  trigger;
    logic [7:0]  trigger_veto;
    logic        ext_trigger_enable;
    logic        trigger_acknowledge;
    logic        trigger_accepted_flag;
    logic        trigger_enabled;
    logic [7:0]  trigger_selected;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;

    int errors;
    int accepts;      // counted by the monitor
    int accept_mark;  // accepts already claimed by commands

    logic [7:0] select_model;  // last value written to the trigger select register

    trigger_controller_top #(.ABUSWIDTH(16), .WIDTH(8), .FIFO_DEPTH(8)) u_dut (
        .BUS_CLK(bus_clk), .RST(rst), .BUS_ADD(bus_add), .BUS_DATA_IN(bus_data_in),
        .BUS_WR(bus_wr), .BUS_RD(bus_rd), .BUS_DATA_OUT(bus_data_out),
        .TRIGGER(trigger), .TRIGGER_VETO(trigger_veto),
        .EXT_TRIGGER_ENABLE(ext_trigger_enable), .TRIGGER_ACKNOWLEDGE(trigger_acknowledge),
        .TRIGGER_ACCEPTED_FLAG(trigger_accepted_flag), .TRIGGER_ENABLED(trigger_enabled),
        .TRIGGER_SELECTED(trigger_selected), .FIFO_READ(fifo_read),
        .FIFO_EMPTY(fifo_empty), .FIFO_DATA(fifo_data)
    );

    bind trigger_fsm trigger_fsm_checker u_fsm_checker (
        .bus_clk(bus_clk), .rst(rst), .trigger_accepted(trigger_accepted),
        .trigger_enabled(trigger_enabled), .word_write(word_write),
        .trigger_word(trigger_word), .trigger_count(trigger_count)
    );

    initial
    begin
        bus_clk = 1'b0;
        forever #20 bus_clk = ~bus_clk;
    end

    always @(posedge bus_clk)
    begin
        if (trigger_accepted_flag)
            accepts = accepts + 1;
    end

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge bus_clk);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge bus_clk);
        bus_wr = 1'b0;
        // address 13 is the select register, a write to 0 resets it
        if (addr == 16'd13)
            select_model = data;
        else if (addr == 16'd0)
            select_model = '0;
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected);
        @(negedge bus_clk);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge bus_clk);
        bus_rd = 1'b0;  // data registered on the edge just passed
        if (bus_data_out !== expected)
        begin
            $display("** Error: bus_data_out at %h = %h, expected %h", addr, bus_data_out,
                     expected);
            errors++;
        end
    endtask

    task automatic drive_pin(input byte op, input logic [7:0] value);
        @(negedge bus_clk);
        case (op)
            "T": trigger = value;
            "V": trigger_veto = value;
            "E": ext_trigger_enable = value[0];
            default: trigger_acknowledge = value[0];
        endcase
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        while (accepts == accept_mark && n < TIMEOUT_CYCLES)
        begin
            @(negedge bus_clk);
            n++;
        end
        if (accepts == accept_mark)
        begin
            $display("timeout while waiting for a trigger accept");
            errors++;
        end
        else
            accept_mark++;  // a second accept shows up at the next idle check
    endtask

    task automatic idle_no_accept(input int cycles);
        repeat (cycles) @(negedge bus_clk);
        if (accepts != accept_mark)
        begin
            $display("unexpected trigger accept, %0d more than expected", accepts - accept_mark);
            errors++;
        end
        accept_mark = accepts;
    endtask

    // pulses on input 0, each held until accepted
    task automatic trigger_pulses(input int count);
        repeat (count)
        begin
            @(negedge bus_clk);
            trigger = 8'h01;
            wait_accept();
            @(negedge bus_clk);
            trigger = 8'h00;
            repeat (4) @(negedge bus_clk);  // through the synchronizer and release
        end
    endtask

    task automatic pop_words(input int count, input logic [31:0] first);
        logic [31:0] expected;
        for (int i = 0; i < count; i++)
        begin
            expected = first + 32'(i);
            @(negedge bus_clk);
            if (fifo_empty)
            begin
                $display("FIFO empty, word %h was still expected", expected);
                errors++;
            end
            else if (fifo_data !== expected)
            begin
                $display("** Error: fifo_data = %h, expected %h", fifo_data, expected);
                errors++;
            end
            fifo_read = !fifo_empty;
            @(negedge bus_clk);
            fifo_read = 1'b0;
        end
    endtask

    task automatic check_status(input logic enabled, input logic empty);
        @(negedge bus_clk);
        if (trigger_enabled !== enabled)
        begin
            $display("** Error: trigger_enabled = %h, expected %h", trigger_enabled, enabled);
            errors++;
        end
        if (fifo_empty !== empty)
        begin
            $display("** Error: fifo_empty = %h, expected %h", fifo_empty, empty);
            errors++;
        end
        if (trigger_selected !== select_model)
        begin
            $display("** Error: trigger_selected = %h, expected %h", trigger_selected,
                     select_model);
            errors++;
        end
    endtask

    task automatic run_command(input string line);
        byte         op;
        logic [31:0] a1;
        logic [31:0] a2;
        a1 = '0;
        a2 = '0;
        void'($sscanf(line, "%c %h %h", op, a1, a2));
        case (op)
            "W": bus_write(a1[15:0], a2[7:0]);
            "R": bus_read(a1[15:0], a2[7:0]);
            "T", "V", "E", "K": drive_pin(op, a1[7:0]);
            "A": wait_accept();
            "Q": idle_no_accept(int'(a1));
            "G": trigger_pulses(int'(a1));
            "D": pop_words(int'(a1), a2);
            "S": check_status(a1[0], a2[0]);
            default:
            begin
                $display("unknown stimulus command: %s", line);
                errors++;
            end
        endcase
    endtask

    initial
    begin
        int    fd;
        string line;
        errors              = 0;
        accepts             = 0;
        accept_mark         = 0;
        select_model        = '0;
        rst                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_wr              = 1'b0;
        bus_rd              = 1'b0;
        trigger             = '0;
        trigger_veto        = '0;
        ext_trigger_enable  = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read           = 1'b0;
        repeat (16) @(negedge bus_clk);
        rst = 1'b0;

        fd = $fopen("bench/trigger_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                    run_command(line);
            end
            $fclose(fd);
        end

        repeat (4) @(negedge bus_clk);
        $display("errors: %0d, accepts seen: %0d", errors, accepts);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== bench/trigger_stimulus.txt ====
# W addr data | R addr expect | T trig | V veto | E ext | K ack | S enabled empty
# A wait accept | Q cycles, no accept | G pulses | D count first_word (all hex)
S 0 1
R 0 0a
R 3 00
W 0d 01
W 21 03
W 01 08
S 1 1
G 1
T 02
Q 8
T 01
Q 1
T 00
W 11 01
V 01
T 01
Q 8
T 00
V 00
W 15 01
A
T 01
Q 6
W 0d 00
W 15 00
T 00
W 21 01
W 0d 01
W 22 00
A
Q 4
D 3 80000000
W 08 78
W 09 56
W 0a 34
W 0b 12
G 2
R 08 7a
R 09 56
R 0a 34
R 0b 12
D 2 92345678
W 0b 00
W 19 7a
W 1a 56
W 1b 34
S 1 1
G 2
S 0 0
T 01
Q 8
T 00
D 2 80345678
S 0 1
W 00 00
R 19 00
W 0d 01
W 01 08
E 01
T 01
A
T 00
T 01
Q 8
K 01
K 00
T 00
E 00
Q 4
G 0a
R 0c 03
D 8 80000000
S 1 1

// ==== vlog.f ====
hdl/trigger_pkg.sv
hdl/trigger_regs.sv
hdl/trigger_input_select.sv
hdl/trigger_fsm.sv
hdl/trigger_counter.sv
hdl/event_fifo.sv
hdl/trigger_controller_top.sv
bench/trigger_fsm_checker.sv
bench/tb_trigger_controller.sv

// ==== Makefile ====
TOP = tb_trigger_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
